// File: src/ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Cycles an address is held before memory data is valid
`define CTRL_MEM_WAIT 3

// Wait counter width that holds CTRL_MEM_WAIT - 1
`define CTRL_WAIT_W 2

`endif

// File: src/isa_pkg.sv
package isa_pkg;

        typedef logic [5:0] opcode_t;
        typedef logic [5:0] funct_t;

        // Opcodes in MIPS numbering
        localparam opcode_t OP_RTYPE = 6'd0;
        localparam opcode_t OP_J     = 6'd2;
        localparam opcode_t OP_JAL   = 6'd3;
        localparam opcode_t OP_BEQ   = 6'd4;
        localparam opcode_t OP_BNE   = 6'd5;
        localparam opcode_t OP_LW    = 6'd35;
        localparam opcode_t OP_SW    = 6'd43;

        // R-type function field
        localparam funct_t FN_BREAK = 6'd13;
        localparam funct_t FN_ADD   = 6'd32;
        localparam funct_t FN_SUB   = 6'd34;
        localparam funct_t FN_AND   = 6'd36;

        // Fields of the instruction register the unit looks at
        typedef struct packed {
                opcode_t op;
                funct_t  funct;
        } instr_fields_t;

        typedef enum logic [3:0] {
                CLS_ADD,
                CLS_SUB,
                CLS_AND,
                CLS_BEQ,
                CLS_BNE,
                CLS_J,
                CLS_JAL,
                CLS_LW,
                CLS_SW,
                CLS_BRK,
                CLS_ILLEGAL             // Unknown opcode or funct
        } instr_class_e;

endpackage

// File: src/ctrl_pkg.sv
package ctrl_pkg;

        typedef enum logic [4:0] {
                ST_FETCH,
                ST_IR_LOAD,
                ST_DECODE,
                ST_ALU_EXEC,
                ST_ALU_WB,
                ST_BR_CMP,
                ST_BR_TAKE,
                ST_LINK,
                ST_JUMP,
                ST_MEM_ADDR,
                ST_MEM_WAIT,
                ST_LOAD_WB,
                ST_STORE,
                ST_EXC_SAVE,
                ST_EXC_VECTOR,
                ST_EXC_JUMP,
                ST_HALT
        } ctrl_state_e;

        typedef enum logic [1:0] {
                PC_SRC_ALU_RESULT,
                PC_SRC_ALU_OUT,
                PC_SRC_JUMP_TARGET,
                PC_SRC_MEM_VECTOR       // Exception vector from memory register
        } pc_src_e;

        typedef enum logic {
                A_SRC_PC,
                A_SRC_REG_A
        } alu_src_a_e;

        typedef enum logic [1:0] {
                B_SRC_REG_B,
                B_SRC_CONST_4,
                B_SRC_OFFSET,
                B_SRC_BRANCH_OFFSET     // Offset shifted left by 2
        } alu_src_b_e;

        typedef enum logic [1:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND
        } alu_op_e;

        typedef enum logic [1:0] {
                IORD_PC,
                IORD_ALU_OUT,
                IORD_VEC_ILLEGAL,
                IORD_VEC_OVERFLOW
        } iord_e;

        typedef enum logic [1:0] {
                DST_RT,
                DST_RD,
                DST_RA
        } reg_dst_e;

        typedef enum logic [1:0] {
                DATA_ALU_OUT,
                DATA_MEM,
                DATA_PC
        } reg_data_e;

        typedef struct packed {
                logic overflow;
                logic equal;
        } alu_flags_t;

        typedef struct packed {
                pc_src_e    pc_src;
                alu_src_a_e alu_src_a;
                alu_src_b_e alu_src_b;
                alu_op_e    alu_op;
                iord_e      iord;
                reg_dst_e   reg_dst;
                reg_data_e  reg_data;
        } mux_sel_t;

        typedef struct packed {
                logic wr;               // Memory write
                logic ir_write;
                logic pc_write;
                logic bank_write;
                logic epc_write;
                logic a_write;
                logic b_write;
                logic alu_out_write;
                logic mem_reg_write;
        } write_en_t;

        typedef struct packed {
                mux_sel_t  sel;
                write_en_t wen;
        } ctrl_word_t;

endpackage

// File: src/instr_decoder.sv
module instr_decoder (
        input  isa_pkg::instr_fields_t instr,
        output isa_pkg::instr_class_e  iclass
);
        import isa_pkg::*;

        always_comb begin
                iclass = CLS_ILLEGAL;
                case (instr.op)
                        OP_RTYPE: begin
                                case (instr.funct)
                                        FN_ADD:   iclass = CLS_ADD;
                                        FN_SUB:   iclass = CLS_SUB;
                                        FN_AND:   iclass = CLS_AND;
                                        FN_BREAK: iclass = CLS_BRK;
                                        default:  iclass = CLS_ILLEGAL;
                                endcase
                        end
                        OP_BEQ:  iclass = CLS_BEQ;
                        OP_BNE:  iclass = CLS_BNE;
                        OP_J:    iclass = CLS_J;
                        OP_JAL:  iclass = CLS_JAL;
                        OP_LW:   iclass = CLS_LW;
                        OP_SW:   iclass = CLS_SW;
                        default: iclass = CLS_ILLEGAL;   // Raises the opcode exception
                endcase
        end

endmodule

// File: src/ctrl_sequencer.sv
`include "ctrl_cfg.svh"

module ctrl_sequencer (
        input  logic                   clk,
        input  logic                   reset,
        input  isa_pkg::instr_class_e  iclass,
        input  ctrl_pkg::alu_flags_t   flags,
        output ctrl_pkg::ctrl_state_e  next_state,
        output logic                   exc_cause,
        output logic                   last_wait,
        output ctrl_pkg::alu_op_e      exec_op
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        localparam logic [`CTRL_WAIT_W-1:0] WAIT_LAST = (`CTRL_WAIT_W)'(`CTRL_MEM_WAIT - 1);

        ctrl_state_e              state;
        instr_class_e             cls_q;        // Class held after decode
        logic [`CTRL_WAIT_W-1:0]  wait_cnt;
        logic [`CTRL_WAIT_W-1:0]  wait_cnt_nxt;
        logic                     cause_q;      // Set for overflow and clear for unknown opcode
        logic                     in_wait;
        logic                     wait_done;
        logic                     taken;

        assign in_wait = (state == ST_FETCH) || (state == ST_MEM_WAIT) ||
                         (state == ST_EXC_VECTOR);
        assign wait_done = (wait_cnt == WAIT_LAST);
        assign taken = (cls_q == CLS_BNE) ? !flags.equal : flags.equal;

        always_comb begin
                next_state = state;
                case (state)
                        ST_FETCH:   if (wait_done) next_state = ST_IR_LOAD;
                        ST_IR_LOAD: next_state = ST_DECODE;
                        ST_DECODE: begin
                                case (iclass)
                                        CLS_ADD, CLS_SUB, CLS_AND: next_state = ST_ALU_EXEC;
                                        CLS_BEQ, CLS_BNE:          next_state = ST_BR_CMP;
                                        CLS_J:                     next_state = ST_JUMP;
                                        CLS_JAL:                   next_state = ST_LINK;
                                        CLS_LW, CLS_SW:            next_state = ST_MEM_ADDR;
                                        CLS_BRK:                   next_state = ST_HALT;
                                        default:                   next_state = ST_EXC_SAVE;
                                endcase
                        end
                        ST_ALU_EXEC: begin
                                // And never traps on overflow
                                if (flags.overflow && cls_q != CLS_AND)
                                        next_state = ST_EXC_SAVE;
                                else
                                        next_state = ST_ALU_WB;
                        end
                        ST_BR_CMP:  next_state = taken ? ST_BR_TAKE : ST_FETCH;
                        ST_LINK:    next_state = ST_JUMP;
                        ST_MEM_ADDR: next_state = (cls_q == CLS_SW) ? ST_STORE : ST_MEM_WAIT;
                        ST_MEM_WAIT: if (wait_done) next_state = ST_LOAD_WB;
                        ST_EXC_SAVE: next_state = ST_EXC_VECTOR;
                        ST_EXC_VECTOR: if (wait_done) next_state = ST_EXC_JUMP;
                        ST_HALT:    next_state = ST_HALT;       // Left only by reset
                        default:    next_state = ST_FETCH;
                endcase
        end

        // Counter restarts on every entry into a wait state
        always_comb begin
                wait_cnt_nxt = '0;
                if (in_wait && next_state == state)
                        wait_cnt_nxt = wait_cnt + 1'b1;
        end

        assign last_wait = (wait_cnt_nxt == WAIT_LAST);
        assign exc_cause = cause_q;

        // Only looked at when decode dispatches to alu_exec
        always_comb begin
                case (iclass)
                        CLS_SUB: exec_op = ALU_SUB;
                        CLS_AND: exec_op = ALU_AND;
                        default: exec_op = ALU_ADD;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ST_FETCH;
                        wait_cnt <= '0;
                        cls_q <= CLS_ILLEGAL;
                        cause_q <= 1'b0;
                end else begin
                        state <= next_state;
                        wait_cnt <= wait_cnt_nxt;
                        if (state == ST_DECODE)
                                cls_q <= iclass;
                        if (next_state == ST_EXC_SAVE)
                                cause_q <= (state == ST_ALU_EXEC);
                end
        end

endmodule

// File: src/ctrl_word_gen.sv
module ctrl_word_gen (
        input  logic                  clk,
        input  logic                  reset,
        input  ctrl_pkg::ctrl_state_e next_state,
        input  logic                  exc_cause,
        input  logic                  last_wait,
        input  ctrl_pkg::alu_op_e     exec_op,
        output ctrl_pkg::ctrl_word_t  ctrl
);
        import ctrl_pkg::*;

        // PC + 4 on the ALU while the instruction is read
        localparam mux_sel_t FETCH_SEL = '{
                pc_src:    PC_SRC_ALU_RESULT,
                alu_src_a: A_SRC_PC,
                alu_src_b: B_SRC_CONST_4,
                alu_op:    ALU_ADD,
                iord:      IORD_PC,
                reg_dst:   DST_RT,
                reg_data:  DATA_ALU_OUT
        };

        ctrl_word_t word_nxt;

        always_comb begin
                word_nxt.sel = FETCH_SEL;
                word_nxt.wen = '0;
                case (next_state)
                        ST_IR_LOAD: begin
                                word_nxt.wen.ir_write = 1'b1;
                                word_nxt.wen.pc_write = 1'b1;
                        end
                        ST_DECODE: begin
                                word_nxt.sel.alu_src_b = B_SRC_BRANCH_OFFSET; // Branch target early
                                word_nxt.wen.a_write = 1'b1;
                                word_nxt.wen.b_write = 1'b1;
                                word_nxt.wen.alu_out_write = 1'b1;
                        end
                        ST_ALU_EXEC: begin
                                word_nxt.sel.alu_src_a = A_SRC_REG_A;
                                word_nxt.sel.alu_src_b = B_SRC_REG_B;
                                word_nxt.sel.alu_op = exec_op;
                                word_nxt.wen.alu_out_write = 1'b1;
                        end
                        ST_ALU_WB: begin
                                word_nxt.sel.reg_dst = DST_RD;
                                word_nxt.wen.bank_write = 1'b1;
                        end
                        ST_BR_CMP: begin
                                word_nxt.sel.alu_src_a = A_SRC_REG_A;
                                word_nxt.sel.alu_src_b = B_SRC_REG_B;
                                word_nxt.sel.alu_op = ALU_SUB;
                        end
                        ST_BR_TAKE: begin
                                word_nxt.sel.pc_src = PC_SRC_ALU_OUT;
                                word_nxt.wen.pc_write = 1'b1;
                        end
                        ST_LINK: begin
                                word_nxt.sel.reg_dst = DST_RA;
                                word_nxt.sel.reg_data = DATA_PC;
                                word_nxt.wen.bank_write = 1'b1;
                        end
                        ST_JUMP: begin
                                word_nxt.sel.pc_src = PC_SRC_JUMP_TARGET;
                                word_nxt.wen.pc_write = 1'b1;
                        end
                        ST_MEM_ADDR: begin
                                word_nxt.sel.alu_src_a = A_SRC_REG_A;
                                word_nxt.sel.alu_src_b = B_SRC_OFFSET;
                                word_nxt.wen.alu_out_write = 1'b1;
                        end
                        ST_MEM_WAIT: begin
                                word_nxt.sel.iord = IORD_ALU_OUT;
                                word_nxt.wen.mem_reg_write = last_wait;
                        end
                        ST_LOAD_WB: begin
                                word_nxt.sel.reg_data = DATA_MEM;
                                word_nxt.wen.bank_write = 1'b1;
                        end
                        ST_STORE: begin
                                word_nxt.sel.iord = IORD_ALU_OUT;
                                word_nxt.wen.wr = 1'b1;
                        end
                        ST_EXC_SAVE: begin
                                word_nxt.sel.alu_op = ALU_SUB;      // PC - 4 into EPC
                                word_nxt.wen.epc_write = 1'b1;
                        end
                        ST_EXC_VECTOR: begin
                                word_nxt.sel.iord = exc_cause ? IORD_VEC_OVERFLOW : IORD_VEC_ILLEGAL;
                                word_nxt.wen.mem_reg_write = last_wait;
                        end
                        ST_EXC_JUMP: begin
                                word_nxt.sel.pc_src = PC_SRC_MEM_VECTOR;
                                word_nxt.wen.pc_write = 1'b1;
                        end
                        default: ;      // Fetch and halt
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset)
                        ctrl <= '{sel: FETCH_SEL, wen: '0};
                else
                        ctrl <= word_nxt;
        end

endmodule

// File: src/control_unit.sv
module control_unit (
        input  logic                   clk,
        input  logic                   reset,
        input  isa_pkg::instr_fields_t instr,
        input  ctrl_pkg::alu_flags_t   flags,
        output ctrl_pkg::ctrl_word_t   ctrl
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        instr_class_e iclass;
        ctrl_state_e  next_state;
        logic         exc_cause;
        logic         last_wait;
        alu_op_e      exec_op;

        instr_decoder u_decoder (
                .instr  (instr),
                .iclass (iclass)
        );

        ctrl_sequencer u_sequencer (
                .clk        (clk),
                .reset      (reset),
                .iclass     (iclass),
                .flags      (flags),
                .next_state (next_state),
                .exc_cause  (exc_cause),
                .last_wait  (last_wait),
                .exec_op    (exec_op)
        );

        // Word is registered alongside the state
        ctrl_word_gen u_word_gen (
                .clk        (clk),
                .reset      (reset),
                .next_state (next_state),
                .exc_cause  (exc_cause),
                .last_wait  (last_wait),
                .exec_op    (exec_op),
                .ctrl       (ctrl)
        );

endmodule

// File: verification/control_unit_properties.sv
module control_unit_properties (
        input logic                 clk,
        input logic                 reset,
        input ctrl_pkg::ctrl_word_t ctrl
);
        timeunit 1ns;
        timeprecision 1ps;

        // New instruction always advances the PC
        ir_with_pc: assert property (@(posedge clk) disable iff (reset)
                ctrl.wen.ir_write |-> ctrl.wen.pc_write)
                else $error("ir_write pulsed without pc_write");

        no_store_and_bank: assert property (@(posedge clk) disable iff (reset)
                !(ctrl.wen.wr && ctrl.wen.bank_write))
                else $error("wr and bank_write set in the same cycle");

        quiet_after_reset: assert property (@(posedge clk)
                reset |=> (ctrl.wen == '0))
                else $error("write enable set in the cycle after reset");

endmodule

bind control_unit control_unit_properties props (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
);

// File: verification/control_unit_tb.sv
`include "ctrl_cfg.svh"

module control_unit_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import isa_pkg::*;
        import ctrl_pkg::*;

        localparam int MAX_CYCLES = 400;

        logic          clk;
        logic          reset;
        instr_fields_t instr;
        alu_flags_t    flags;
        ctrl_word_t    ctrl;
        int            cycles = 0;

        control_unit dut (
                .clk   (clk),
                .reset (reset),
                .instr (instr),
                .flags (flags),
                .ctrl  (ctrl)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
                        $display("TEST FAIL");
                        $fatal(1, "timeout");
                end
        end

        // Selects while PC + 4 is formed and the instruction is read
        function automatic mux_sel_t fetch_sel();
                mux_sel_t s;
                s.pc_src = PC_SRC_ALU_RESULT;
                s.alu_src_a = A_SRC_PC;
                s.alu_src_b = B_SRC_CONST_4;
                s.alu_op = ALU_ADD;
                s.iord = IORD_PC;
                s.reg_dst = DST_RT;
                s.reg_data = DATA_ALU_OUT;
                return s;
        endfunction

        task automatic compare_sel(input mux_sel_t got, input mux_sel_t exp, input string msg);
                if (got !== exp) begin
                        $display("Fail at %0d ns: %s selects got %h expected %h",
                                 $time, msg, got, exp);
                        $display("TEST FAIL");
                        $fatal(1, "select mismatch");
                end
        endtask

        task automatic compare_wen(input write_en_t got, input write_en_t exp, input string msg);
                if (got !== exp) begin
                        $display("Fail at %0d ns: %s write enables got %b expected %b",
                                 $time, msg, got, exp);
                        $display("TEST FAIL");
                        $fatal(1, "write enable mismatch");
                end
        endtask

        // Check the word of the current state and move to the next cycle
        task automatic check_cycle(input mux_sel_t sel, input write_en_t wen, input string msg);
                compare_sel(ctrl.sel, sel, msg);
                compare_wen(ctrl.wen, wen, msg);
                @(negedge clk);
        endtask

        task automatic fetch_decode(input opcode_t op, input funct_t fn);
                mux_sel_t  s;
                write_en_t w;
                instr.op = op;
                instr.funct = fn;
                flags = '0;
                s = fetch_sel();
                w = '0;
                repeat (`CTRL_MEM_WAIT) check_cycle(s, w, "fetch");
                w.ir_write = 1'b1;
                w.pc_write = 1'b1;
                check_cycle(s, w, "ir_load");
                w = '0;
                s.alu_src_b = B_SRC_BRANCH_OFFSET;
                w.a_write = 1'b1;
                w.b_write = 1'b1;
                w.alu_out_write = 1'b1;
                check_cycle(s, w, "decode");
        endtask

        task automatic exception_seq(input logic overflow);
                mux_sel_t  s;
                write_en_t w;
                s = fetch_sel();
                s.alu_op = ALU_SUB;     // PC - 4
                w = '0;
                w.epc_write = 1'b1;
                check_cycle(s, w, "exc_save");
                s = fetch_sel();
                s.iord = overflow ? IORD_VEC_OVERFLOW : IORD_VEC_ILLEGAL;
                w = '0;
                for (int i = 0; i < `CTRL_MEM_WAIT; i++) begin
                        w.mem_reg_write = (i == `CTRL_MEM_WAIT - 1);
                        check_cycle(s, w, "exc_vector");
                end
                s = fetch_sel();
                s.pc_src = PC_SRC_MEM_VECTOR;
                w = '0;
                w.pc_write = 1'b1;
                check_cycle(s, w, "exc_jump");
        endtask

        task automatic alu_test(input funct_t fn, input alu_op_e op, input logic ovf);
                mux_sel_t  s;
                write_en_t w;
                fetch_decode(OP_RTYPE, fn);
                flags.overflow = ovf;
                s = fetch_sel();
                s.alu_src_a = A_SRC_REG_A;
                s.alu_src_b = B_SRC_REG_B;
                s.alu_op = op;
                w = '0;
                w.alu_out_write = 1'b1;
                check_cycle(s, w, "alu_exec");
                flags = '0;
                if (ovf && op != ALU_AND) begin
                        exception_seq(1'b1);
                end else begin
                        s = fetch_sel();
                        s.reg_dst = DST_RD;
                        w = '0;
                        w.bank_write = 1'b1;
                        check_cycle(s, w, "alu_wb");
                end
        endtask

        task automatic branch_test(input opcode_t op, input logic eq);
                mux_sel_t  s;
                write_en_t w;
                fetch_decode(op, 6'd0);
                flags.equal = eq;
                s = fetch_sel();
                s.alu_src_a = A_SRC_REG_A;
                s.alu_src_b = B_SRC_REG_B;
                s.alu_op = ALU_SUB;
                w = '0;
                check_cycle(s, w, "br_cmp");
                flags = '0;
                if ((op == OP_BEQ) == eq) begin         // Taken
                        s = fetch_sel();
                        s.pc_src = PC_SRC_ALU_OUT;
                        w.pc_write = 1'b1;
                        check_cycle(s, w, "br_take");
                end
        endtask

        task automatic jump_test(input logic link);
                mux_sel_t  s;
                write_en_t w;
                fetch_decode(link ? OP_JAL : OP_J, 6'd0);
                if (link) begin
                        s = fetch_sel();
                        s.reg_dst = DST_RA;
                        s.reg_data = DATA_PC;
                        w = '0;
                        w.bank_write = 1'b1;
                        check_cycle(s, w, "link");
                end
                s = fetch_sel();
                s.pc_src = PC_SRC_JUMP_TARGET;
                w = '0;
                w.pc_write = 1'b1;
                check_cycle(s, w, "jump");
        endtask

        task automatic mem_test(input logic store);
                mux_sel_t  s;
                write_en_t w;
                fetch_decode(store ? OP_SW : OP_LW, 6'd0);
                s = fetch_sel();
                s.alu_src_a = A_SRC_REG_A;
                s.alu_src_b = B_SRC_OFFSET;
                w = '0;
                w.alu_out_write = 1'b1;
                check_cycle(s, w, "mem_addr");
                s = fetch_sel();
                s.iord = IORD_ALU_OUT;
                w = '0;
                if (store) begin
                        w.wr = 1'b1;
                        check_cycle(s, w, "store");
                end else begin
                        for (int i = 0; i < `CTRL_MEM_WAIT; i++) begin
                                w.mem_reg_write = (i == `CTRL_MEM_WAIT - 1);
                                check_cycle(s, w, "mem_wait");
                        end
                        s = fetch_sel();
                        s.reg_data = DATA_MEM;
                        w = '0;
                        w.bank_write = 1'b1;
                        check_cycle(s, w, "load_wb");
                end
        endtask

        task automatic illegal_test(input opcode_t op, input funct_t fn);
                fetch_decode(op, fn);
                exception_seq(1'b0);
        endtask

        task automatic break_test();
                fetch_decode(OP_RTYPE, FN_BREAK);
                repeat (20) check_cycle(fetch_sel(), '0, "halt");
        endtask

        initial begin
                reset = 1'b1;
                instr = '0;
                flags = '0;
                repeat (8) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                alu_test(FN_ADD, ALU_ADD, 1'b0);
                alu_test(FN_SUB, ALU_SUB, 1'b0);
                alu_test(FN_AND, ALU_AND, 1'b0);
                alu_test(FN_ADD, ALU_ADD, 1'b1);
                alu_test(FN_SUB, ALU_SUB, 1'b1);
                alu_test(FN_AND, ALU_AND, 1'b1);        // No trap for and
                branch_test(OP_BEQ, 1'b1);
                branch_test(OP_BEQ, 1'b0);
                branch_test(OP_BNE, 1'b1);
                branch_test(OP_BNE, 1'b0);
                jump_test(1'b0);
                jump_test(1'b1);
                mem_test(1'b0);
                mem_test(1'b1);
                illegal_test(6'd63, 6'd0);              // Unknown opcode
                illegal_test(OP_RTYPE, 6'd1);           // Unknown funct
                break_test();
                $display("TEST PASS");
                $finish;
        end

endmodule

// File: control_unit.f
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/instr_decoder.sv
src/ctrl_sequencer.sv
src/ctrl_word_gen.sv
src/control_unit.sv
verification/control_unit_properties.sv
verification/control_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module control_unit_tb -f control_unit.f
./obj_dir/Vcontrol_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi
